//--- rtl/dev_tbl.sv
`default_nettype none

module dev_tbl (
	input  wire   clk120mhz,
	input  wire   sys_rst_i,
	pi1_if.slave  bus,
	output soc_map_pkg::sw_rst_t sw_rst_req_o
);

	logic               req_new;
	logic               wr_ctrl;
	logic               rdy_q;
	soc_bus_pkg::word_t rdata_q;
	soc_bus_pkg::word_t rd_word;
	int                 slave_id;
	int                 slave_mapsz;
	bit                 slave_useintr;

	// swap is not decoded here and behaves as a read
	assign req_new = (bus.op != soc_bus_pkg::OP_NOP) && !rdy_q;
	assign wr_ctrl = req_new && (bus.op == soc_bus_pkg::OP_WR) && bus.sel[0] &&
		(bus.addr == soc_bus_pkg::waddr_t'(soc_map_pkg::DEVTBL_CTRL_WORD));

	// two words per slave, even word is id and flag, odd word is map size
	always_comb begin
		slave_id      = 0;
		slave_mapsz   = 0;
		slave_useintr = 1'b0;
		case (int'(bus.addr >> 1))
			soc_map_pkg::S_DEVTBL: begin
				slave_id      = soc_map_pkg::DEVTBL_ID;
				slave_mapsz   = soc_map_pkg::DEVTBL_MAPSZ;
				slave_useintr = soc_map_pkg::DEVTBL_USEINTR;
			end
			soc_map_pkg::S_INTCTRL: begin
				slave_id      = soc_map_pkg::INTCTRL_ID;
				slave_mapsz   = soc_map_pkg::INTCTRL_MAPSZ;
				slave_useintr = soc_map_pkg::INTCTRL_USEINTR;
			end
			soc_map_pkg::S_INVALID: begin
				slave_id      = soc_map_pkg::INVALID_ID;
				slave_mapsz   = soc_map_pkg::INVALID_MAPSZ;
				slave_useintr = soc_map_pkg::INVALID_USEINTR;
			end
			default: ;
		endcase

		if (bus.addr == soc_bus_pkg::waddr_t'(soc_map_pkg::DEVTBL_CTRL_WORD)) begin
			rd_word = soc_bus_pkg::word_t'(soc_map_pkg::SLAVE_COUNT);
		end else if (bus.addr[0]) begin
			rd_word = soc_bus_pkg::word_t'(slave_mapsz);
		end else begin
			rd_word = {slave_id[soc_bus_pkg::ARCH_BITS-2:0], slave_useintr};
		end
	end

	// rdy one cycle after the request, reset request pulses for one cycle
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rdy_q        <= 1'b0;
			sw_rst_req_o <= soc_map_pkg::SWRST_NONE;
		end else begin
			rdy_q        <= req_new;
			sw_rst_req_o <= wr_ctrl ? soc_map_pkg::sw_rst_t'(bus.wdata[1:0])
				: soc_map_pkg::SWRST_NONE;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_new) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- rtl/int_ctrl.sv
`default_nettype none

module int_ctrl (
	input  wire                                  clk120mhz,
	input  wire                                  sys_rst_i,
	pi1_if.slave                                 bus,
	input  wire  [soc_map_pkg::INTSRC_COUNT-1:0] intrqst_src_i,
	output logic [soc_map_pkg::INTSRC_COUNT-1:0] intrdy_src_o,
	output logic                                 intrqst_o
);

	logic [soc_map_pkg::INTSRC_COUNT-1:0] pending_q;
	logic [soc_map_pkg::INTSRC_COUNT-1:0] mask_q;
	logic [soc_map_pkg::INTSRC_COUNT-1:0] ack_vec;
	logic [soc_map_pkg::INTSRC_COUNT-1:0] active;
	logic                                 req_new;
	logic                                 wr_req;
	logic                                 rdy_q;
	soc_bus_pkg::word_t                   rdata_q;
	soc_bus_pkg::word_t                   rd_word;
	soc_bus_pkg::word_t                   first_idx;

	assign req_new = (bus.op != soc_bus_pkg::OP_NOP) && !rdy_q;
	assign wr_req  = req_new && (bus.op == soc_bus_pkg::OP_WR) && bus.sel[0];
	assign active  = pending_q & mask_q;

	// an out of range index acknowledges nothing
	always_comb begin
		ack_vec = '0;
		for (int i = 0; i < soc_map_pkg::INTSRC_COUNT; i++) begin
			if (wr_req && bus.addr == soc_bus_pkg::waddr_t'(soc_map_pkg::INTC_ACK_WORD) &&
				bus.wdata == soc_bus_pkg::word_t'(i)) begin
				ack_vec[i] = 1'b1;
			end
		end
	end

	// lowest enabled pending source, all ones when idle
	always_comb begin
		first_idx = '1;
		for (int i = soc_map_pkg::INTSRC_COUNT - 1; i >= 0; i--) begin
			if (active[i]) begin
				first_idx = soc_bus_pkg::word_t'(i);
			end
		end
	end

	always_comb begin
		rd_word = '0;
		if (bus.addr == soc_bus_pkg::waddr_t'(soc_map_pkg::INTC_ACK_WORD)) begin
			rd_word = first_idx;
		end else if (bus.addr == soc_bus_pkg::waddr_t'(soc_map_pkg::INTC_MASK_WORD)) begin
			rd_word = soc_bus_pkg::word_t'(mask_q);
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rdy_q        <= 1'b0;
			intrdy_src_o <= '0;
			pending_q    <= '0;
			mask_q       <= '0;
		end else begin
			rdy_q        <= req_new;
			intrdy_src_o <= ack_vec;
			// a source has one cycle after its ack pulse to drop the request
			pending_q <= (pending_q | (intrqst_src_i & ~intrdy_src_o)) & ~ack_vec;
			if (wr_req && bus.addr == soc_bus_pkg::waddr_t'(soc_map_pkg::INTC_MASK_WORD)) begin
				mask_q <= bus.wdata[soc_map_pkg::INTSRC_COUNT-1:0];
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (req_new) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;
	assign intrqst_o = |active;

endmodule

`default_nettype wire

//--- rtl/pi1_if.sv
`default_nettype none

interface pi1_if;

	soc_bus_pkg::pi1_op_t op;
	soc_bus_pkg::waddr_t  addr;
	soc_bus_pkg::word_t   wdata;
	soc_bus_pkg::word_t   rdata;
	soc_bus_pkg::sel_t    sel;
	// one-cycle completion strobe from the slave
	logic                 rdy;

	modport master (
		output op, addr, wdata, sel,
		input  rdata, rdy
	);

	modport slave (
		input  op, addr, wdata, sel,
		output rdata, rdy
	);

endinterface

`default_nettype wire

//--- rtl/pi1_router.sv
`default_nettype none

module pi1_router (
	input  wire   clk120mhz,
	pi1_if.slave  m_bus,
	pi1_if.master s_devtbl,
	pi1_if.master s_intctrl
);

	logic [soc_map_pkg::SLAVE_COUNT-1:0] hit;
	logic [soc_map_pkg::SLAVE_COUNT-1:0] sel_q;
	logic [soc_map_pkg::SLAVE_COUNT-1:0] cur_sel;
	logic                                in_flight_q;
	soc_bus_pkg::waddr_t                 devtbl_off;
	soc_bus_pkg::waddr_t                 intctrl_off;

	// offsets wrap below the base so one compare checks both bounds
	assign devtbl_off  = m_bus.addr - soc_bus_pkg::waddr_t'(soc_map_pkg::DEVTBL_BASE);
	assign intctrl_off = m_bus.addr - soc_bus_pkg::waddr_t'(soc_map_pkg::INTCTRL_BASE);

	// one-hot slave select
	always_comb begin
		hit = '0;
		if (devtbl_off < soc_bus_pkg::waddr_t'(soc_map_pkg::DEVTBL_MAPSZ)) begin
			hit[soc_map_pkg::S_DEVTBL] = 1'b1;
		end else if (intctrl_off < soc_bus_pkg::waddr_t'(soc_map_pkg::INTCTRL_MAPSZ)) begin
			hit[soc_map_pkg::S_INTCTRL] = 1'b1;
		end else begin
			hit[soc_map_pkg::DEFAULT_SLAVE] = 1'b1;
		end
	end

	// keep the routing of a transfer fixed until its slave answers
	always_ff @(posedge clk120mhz) begin
		in_flight_q <= (m_bus.op != soc_bus_pkg::OP_NOP) && !m_bus.rdy;
		if (!in_flight_q) begin
			sel_q <= hit;
		end
	end

	assign cur_sel = in_flight_q ? sel_q : hit;

	// request fan-out, slaves see addresses relative to their base
	assign s_devtbl.op    = cur_sel[soc_map_pkg::S_DEVTBL] ? m_bus.op : soc_bus_pkg::OP_NOP;
	assign s_devtbl.addr  = devtbl_off;
	assign s_devtbl.wdata = m_bus.wdata;
	assign s_devtbl.sel   = m_bus.sel;

	assign s_intctrl.op    = cur_sel[soc_map_pkg::S_INTCTRL] ? m_bus.op : soc_bus_pkg::OP_NOP;
	assign s_intctrl.addr  = intctrl_off;
	assign s_intctrl.wdata = m_bus.wdata;
	assign s_intctrl.sel   = m_bus.sel;

	always_comb begin
		if (cur_sel[soc_map_pkg::S_DEVTBL]) begin
			m_bus.rdata = s_devtbl.rdata;
			m_bus.rdy   = s_devtbl.rdy;
		end else if (cur_sel[soc_map_pkg::S_INTCTRL]) begin
			m_bus.rdata = s_intctrl.rdata;
			m_bus.rdy   = s_intctrl.rdy;
		end else begin
			// invalid device reads as zero and is always ready
			m_bus.rdata = '0;
			m_bus.rdy   = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rst_ctrl.sv
`default_nettype none

module rst_ctrl (
	input  wire                  clk120mhz,
	input  wire                  rst_p,
	input  wire soc_map_pkg::sw_rst_t sw_rst_req_i,
	output logic                 sys_rst_o
);

	logic [soc_map_pkg::RST_CNTR_BITS-1:0] rst_cntr;
	logic pwroff_q;
	logic warm_req;
	logic pwroff_req;

	// cold requests are ignored here
	always_comb begin
		warm_req   = 1'b0;
		pwroff_req = 1'b0;
		case (sw_rst_req_i)
			soc_map_pkg::SWRST_WARM:   warm_req   = 1'b1;
			soc_map_pkg::SWRST_PWROFF: pwroff_req = 1'b1;
			default: ;
		endcase
	end

	// reload on any reset source, then count down to release
	always_ff @(posedge clk120mhz) begin
		if (rst_p || warm_req) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// only the external reset brings the system back from power-off
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0) || pwroff_q;

endmodule

`default_nettype wire

//--- rtl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	// one bus word
	localparam int ARCH_BITS = 32;
	localparam int SEL_BITS  = ARCH_BITS / 8;
	// word address, the byte offset is not carried on the bus
	localparam int ADDR_BITS = ARCH_BITS - $clog2(SEL_BITS);

	typedef enum logic [1:0] {
		OP_NOP = 2'b00,
		OP_WR  = 2'b01,
		OP_RD  = 2'b10,
		OP_RW  = 2'b11
	} pi1_op_t;

	typedef logic [ARCH_BITS-1:0] word_t;
	typedef logic [ADDR_BITS-1:0] waddr_t;
	typedef logic [SEL_BITS-1:0]  sel_t;

endpackage

`default_nettype wire

//--- rtl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// slave slots on the bus
	localparam int S_DEVTBL      = 0;
	localparam int S_INTCTRL     = 1;
	localparam int S_INVALID     = 2;
	localparam int SLAVE_COUNT   = 3;
	// catches every unmapped access
	localparam int DEFAULT_SLAVE = S_INVALID;

	// map sizes in words
	localparam int DEVTBL_MAPSZ  = 16;
	localparam int INTCTRL_MAPSZ = 16;
	localparam int INVALID_MAPSZ = 1024;

	// slaves packed back to back from address 0
	localparam int DEVTBL_BASE  = 0;
	localparam int INTCTRL_BASE = DEVTBL_BASE + DEVTBL_MAPSZ;

	localparam int DEVTBL_ID  = 7;
	localparam int INTCTRL_ID = 3;
	localparam int INVALID_ID = 0;

	localparam bit DEVTBL_USEINTR  = 1'b0;
	localparam bit INTCTRL_USEINTR = 1'b0;
	localparam bit INVALID_USEINTR = 1'b0;

	// software reset control word in the device table
	localparam int DEVTBL_CTRL_WORD = 15;

	localparam int INTSRC_SDCARD = 0;
	localparam int INTSRC_DMA    = 1;
	localparam int INTSRC_UART   = 2;
	localparam int INTSRC_COUNT  = 3;

	localparam int INTC_ACK_WORD  = 0;
	localparam int INTC_MASK_WORD = 1;

	localparam int RST_CNTR_BITS = 4;

	typedef enum logic [1:0] {
		SWRST_NONE   = 2'b00,
		SWRST_PWROFF = 2'b01,
		SWRST_WARM   = 2'b10,
		SWRST_COLD   = 2'b11
	} sw_rst_t;

endpackage

`default_nettype wire

//--- rtl/soc_top.sv
`default_nettype none

module soc_top (
	input  wire                                  clk120mhz,
	input  wire                                  rst_p,
	input  wire soc_bus_pkg::pi1_op_t            m_op_i,
	input  wire soc_bus_pkg::waddr_t             m_addr_i,
	input  wire soc_bus_pkg::word_t              m_data_i,
	input  wire soc_bus_pkg::sel_t               m_sel_i,
	output soc_bus_pkg::word_t                   m_data_o,
	output logic                                 m_rdy_o,
	input  wire  [soc_map_pkg::INTSRC_COUNT-1:0] intrqst_src_i,
	output logic [soc_map_pkg::INTSRC_COUNT-1:0] intrdy_src_o,
	output logic                                 intrqst_o,
	output logic                                 sys_rst_o
);

	soc_map_pkg::sw_rst_t sw_rst_req;

	pi1_if m_bus ();
	pi1_if devtbl_bus ();
	pi1_if intctrl_bus ();

	// external master onto the bus
	assign m_bus.op    = m_op_i;
	assign m_bus.addr  = m_addr_i;
	assign m_bus.wdata = m_data_i;
	assign m_bus.sel   = m_sel_i;
	assign m_data_o    = m_bus.rdata;
	assign m_rdy_o     = m_bus.rdy;

	rst_ctrl u_rst_ctrl (
		.clk120mhz    (clk120mhz),
		.rst_p        (rst_p),
		.sw_rst_req_i (sw_rst_req),
		.sys_rst_o    (sys_rst_o)
	);

	pi1_router u_router (
		.clk120mhz (clk120mhz),
		.m_bus     (m_bus),
		.s_devtbl  (devtbl_bus),
		.s_intctrl (intctrl_bus)
	);

	dev_tbl u_dev_tbl (
		.clk120mhz    (clk120mhz),
		.sys_rst_i    (sys_rst_o),
		.bus          (devtbl_bus),
		.sw_rst_req_o (sw_rst_req)
	);

	int_ctrl u_int_ctrl (
		.clk120mhz     (clk120mhz),
		.sys_rst_i     (sys_rst_o),
		.bus           (intctrl_bus),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_src_o  (intrdy_src_o),
		.intrqst_o     (intrqst_o)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tb_top

out=$(./obj_dir/Vtb_top) || true
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
	exit 0
fi
exit 1

//--- tb.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/pi1_if.sv
rtl/rst_ctrl.sv
rtl/pi1_router.sv
rtl/dev_tbl.sv
rtl/int_ctrl.sv
rtl/soc_top.sv
verif/tb_clkgen.sv
verif/soc_asserts.sv
verif/tb_top.sv

//--- verif/soc_asserts.sv
`default_nettype none

module soc_asserts (
	input wire                                  clk120mhz,
	input wire                                  rst_p,
	input wire soc_bus_pkg::pi1_op_t            m_op_i,
	input wire soc_bus_pkg::waddr_t             m_addr_i,
	input wire                                  m_rdy_i,
	input wire [soc_map_pkg::INTSRC_COUNT-1:0]  intrdy_src_i,
	input wire                                  intrqst_i,
	input wire                                  sys_rst_i,
	input wire soc_map_pkg::sw_rst_t            sw_rst_req_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// first word above the mapped slaves, the default slave answers every cycle there
	localparam int MAPPED_END = soc_map_pkg::INTCTRL_BASE + soc_map_pkg::INTCTRL_MAPSZ;

	logic pwroff_seen;

	// set on the same edge as the power-off latch in the sequencer
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_seen <= 1'b0;
		end else if (sw_rst_req_i == soc_map_pkg::SWRST_PWROFF) begin
			pwroff_seen <= 1'b1;
		end
	end

	ack_one_hot: assert property (@(posedge clk120mhz) disable iff (rst_p)
		$onehot0(intrdy_src_i))
		else $error("more than one intrdy_src_o bit set");

	rdy_one_cycle: assert property (@(posedge clk120mhz) disable iff (rst_p)
		m_rdy_i && (m_op_i != soc_bus_pkg::OP_NOP) &&
		(m_addr_i < soc_bus_pkg::waddr_t'(MAPPED_END)) |=> !m_rdy_i)
		else $error("m_rdy_o from a mapped slave held longer than one cycle");

	// interrupt registers clear on the first edge inside the system reset
	no_irq_in_reset: assert property (@(posedge clk120mhz) disable iff (rst_p)
		sys_rst_i && $past(sys_rst_i) |-> !intrqst_i)
		else $error("intrqst_o high during system reset");

	pwroff_holds: assert property (@(posedge clk120mhz) disable iff (rst_p)
		pwroff_seen |-> sys_rst_i)
		else $error("sys_rst_o released after power-off without rst_p");

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// half of the 4 ns period
	localparam int HALF_PERIOD = 2;

	initial begin
		clk_o = 1'b0;
	end

	always begin
		#HALF_PERIOD clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`default_nettype none

module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	// the whole run takes a few hundred cycles
	localparam int MAX_CYCLES   = 5000;
	localparam int BUS_WAIT_MAX = 16;
	localparam int RST_WAIT_MAX = 20;
	localparam int CTRL_WORD    = soc_map_pkg::DEVTBL_BASE + soc_map_pkg::DEVTBL_CTRL_WORD;
	localparam int INTC_ACK     = soc_map_pkg::INTCTRL_BASE + soc_map_pkg::INTC_ACK_WORD;
	localparam int INTC_MASK    = soc_map_pkg::INTCTRL_BASE + soc_map_pkg::INTC_MASK_WORD;

	logic                                 clk;
	logic                                 rst_p;
	soc_bus_pkg::pi1_op_t                 m_op;
	soc_bus_pkg::waddr_t                  m_addr;
	soc_bus_pkg::word_t                   m_wdata;
	soc_bus_pkg::sel_t                    m_sel;
	soc_bus_pkg::word_t                   m_rdata;
	logic                                 m_rdy;
	logic [soc_map_pkg::INTSRC_COUNT-1:0] int_src;
	logic [soc_map_pkg::INTSRC_COUNT-1:0] int_ack;
	logic                                 int_req;
	logic                                 sys_rst;
	int                                   errors = 0;
	int                                   checks = 0;
	int                                   cycle_cnt = 0;
	int                                   ack_pulses [soc_map_pkg::INTSRC_COUNT] = '{default: 0};
	integer                               seed = 32'hb2f;

	tb_clkgen u_clkgen (
		.clk_o (clk)
	);

	soc_top i_dut (
		.clk120mhz     (clk),
		.rst_p         (rst_p),
		.m_op_i        (m_op),
		.m_addr_i      (m_addr),
		.m_data_i      (m_wdata),
		.m_sel_i       (m_sel),
		.m_data_o      (m_rdata),
		.m_rdy_o       (m_rdy),
		.intrqst_src_i (int_src),
		.intrdy_src_o  (int_ack),
		.intrqst_o     (int_req),
		.sys_rst_o     (sys_rst)
	);

	bind soc_top soc_asserts u_asserts (
		.clk120mhz    (clk120mhz),
		.rst_p        (rst_p),
		.m_op_i       (m_op_i),
		.m_addr_i     (m_addr_i),
		.m_rdy_i      (m_rdy_o),
		.intrdy_src_i (intrdy_src_o),
		.intrqst_i    (intrqst_o),
		.sys_rst_i    (sys_rst_o),
		.sw_rst_req_i (sw_rst_req)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ack pulses are one cycle wide, so one falling edge sees each
	always @(negedge clk) begin
		for (int i = 0; i < soc_map_pkg::INTSRC_COUNT; i++) begin
			if (int_ack[i] === 1'b1) begin
				ack_pulses[i] <= ack_pulses[i] + 1;
			end
		end
	end

	task automatic check_equal(input string what, input soc_bus_pkg::word_t expected,
		input soc_bus_pkg::word_t actual);
		checks++;
		if (expected !== actual) begin
			$display("FAILED at %0d ns: %s, expected 0x%08h, got 0x%08h",
				$time, what, expected, actual);
			errors++;
		end
	endtask

	// holds the request until m_rdy_o is seen at a rising edge
	task automatic bus_access(input soc_bus_pkg::pi1_op_t op, input int addr,
		input soc_bus_pkg::word_t wdata, output soc_bus_pkg::word_t rdata);
		int  waited;
		bit  done;
		waited = 0;
		done   = 1'b0;
		rdata  = '0;
		@(negedge clk);
		m_op    = op;
		m_addr  = soc_bus_pkg::waddr_t'(addr);
		m_wdata = wdata;
		m_sel   = '1;
		while (!done && waited < BUS_WAIT_MAX) begin
			@(posedge clk);
			if (m_rdy === 1'b1) begin
				rdata = m_rdata;
				done  = 1'b1;
			end
			waited++;
		end
		if (!done) begin
			$display("bus access to word 0x%0h got no m_rdy_o within %0d cycles",
				addr, BUS_WAIT_MAX);
			errors++;
		end
		@(negedge clk);
		m_op = soc_bus_pkg::OP_NOP;
	endtask

	task automatic bus_write(input int addr, input soc_bus_pkg::word_t data);
		soc_bus_pkg::word_t unused;
		bus_access(soc_bus_pkg::OP_WR, addr, data, unused);
	endtask

	task automatic read_check(input int addr, input soc_bus_pkg::word_t expected,
		input string what);
		soc_bus_pkg::word_t data;
		bus_access(soc_bus_pkg::OP_RD, addr, '0, data);
		check_equal($sformatf("%s at word 0x%0h", what, addr), expected, data);
	endtask

	task automatic count_release(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (sys_rst === 1'b1 && cycles < RST_WAIT_MAX);
	endtask

	task automatic count_reset_high(input int cycles, output int highs);
		highs = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (sys_rst === 1'b1) begin
				highs++;
			end
		end
	endtask

	// 4-cycle rst_p pulse after which the countdown needs 15 edges
	task automatic pulse_reset(input string what);
		int cycles;
		rst_p = 1'b1;
		repeat (4) @(negedge clk);
		rst_p = 1'b0;
		count_release(cycles);
		check_equal(what, 15, cycles);
	endtask

	task automatic test_reset_release();
		pulse_reset("cycles from rst_p release to sys_rst_o low");
		check_equal("intrqst_o after reset", 0, 32'(int_req));
		check_equal("intrdy_src_o after reset", 0, 32'(int_ack));
	endtask

	task automatic test_dev_table();
		int ids [soc_map_pkg::SLAVE_COUNT];
		int sizes [soc_map_pkg::SLAVE_COUNT];
		int flags [soc_map_pkg::SLAVE_COUNT];
		// in slave index order
		ids   = '{soc_map_pkg::DEVTBL_ID, soc_map_pkg::INTCTRL_ID, soc_map_pkg::INVALID_ID};
		sizes = '{soc_map_pkg::DEVTBL_MAPSZ, soc_map_pkg::INTCTRL_MAPSZ,
			soc_map_pkg::INVALID_MAPSZ};
		flags = '{int'(soc_map_pkg::DEVTBL_USEINTR), int'(soc_map_pkg::INTCTRL_USEINTR),
			int'(soc_map_pkg::INVALID_USEINTR)};
		for (int k = 0; k < soc_map_pkg::SLAVE_COUNT; k++) begin
			// id sits above the interrupt flag
			read_check(2 * k, (ids[k] << 1) | flags[k], "device id and flag");
			read_check(2 * k + 1, sizes[k], "device map size");
		end
		read_check(CTRL_WORD, soc_map_pkg::SLAVE_COUNT, "slave count");
		read_check(2 * soc_map_pkg::SLAVE_COUNT, 0, "unused device table word");
	endtask

	task automatic test_invalid_region();
		logic [31:0] rnd;
		int          addr;
		repeat (20) begin
			rnd = $random(seed);
			// bit 5 keeps the address at 32 or above
			addr = int'(rnd[29:0]) | 32;
			read_check(addr, 0, "invalid device read");
			bus_write(addr, $random(seed));
		end
		read_check(0, soc_map_pkg::DEVTBL_ID << 1, "device table after invalid writes");
		check_equal("sys_rst_o after invalid writes", 0, 32'(sys_rst));
	endtask

	task automatic test_interrupts();
		int acks_before;
		bus_write(INTC_MASK, 5);
		@(negedge clk);
		int_src = 3'b101;
		@(negedge clk);
		check_equal("intrqst_o with sources 0 and 2 enabled", 1, 32'(int_req));
		read_check(INTC_ACK, soc_map_pkg::INTSRC_SDCARD, "first pending source");
		acks_before = ack_pulses[soc_map_pkg::INTSRC_SDCARD];
		bus_write(INTC_ACK, soc_map_pkg::INTSRC_SDCARD);
		// source releases its request right after the ack
		int_src[soc_map_pkg::INTSRC_SDCARD] = 1'b0;
		check_equal("ack pulses for source 0", 1,
			ack_pulses[soc_map_pkg::INTSRC_SDCARD] - acks_before);
		read_check(INTC_ACK, soc_map_pkg::INTSRC_UART, "pending source after ack");
		bus_write(INTC_MASK, 0);
		check_equal("intrqst_o with mask cleared", 0, 32'(int_req));
		read_check(INTC_ACK, 32'hffff_ffff, "no enabled source");
		int_src = '0;
	endtask

	task automatic test_warm_reset();
		int cycles;
		int highs;
		bus_write(INTC_MASK, 3);
		read_check(INTC_MASK, 3, "interrupt mask before warm reset");
		bus_write(CTRL_WORD, 32'(soc_map_pkg::SWRST_WARM));
		check_equal("sys_rst_o after warm request", 1, 32'(sys_rst));
		count_release(cycles);
		check_equal("cycles until warm reset ends", 15, cycles);
		read_check(INTC_MASK, 0, "interrupt mask after warm reset");
		bus_write(CTRL_WORD, 32'(soc_map_pkg::SWRST_COLD));
		count_reset_high(RST_WAIT_MAX, highs);
		check_equal("sys_rst_o cycles after cold request", 0, highs);
	endtask

	task automatic test_power_off();
		int highs;
		bus_write(CTRL_WORD, 32'(soc_map_pkg::SWRST_PWROFF));
		count_reset_high(100, highs);
		check_equal("sys_rst_o cycles held after power-off", 100, highs);
		pulse_reset("cycles from rst_p release after power-off");
		read_check(CTRL_WORD, soc_map_pkg::SLAVE_COUNT, "slave count after power-off");
	endtask

	initial begin
		rst_p   = 1'b1;
		m_op    = soc_bus_pkg::OP_NOP;
		m_addr  = '0;
		m_wdata = '0;
		m_sel   = '0;
		int_src = '0;
		test_reset_release();
		test_dev_table();
		test_invalid_region();
		test_interrupts();
		test_warm_reset();
		test_power_off();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
